//--- hdl/cpu_pkg.sv
package cpu_pkg;

	// Machine word
	localparam int data_width = 16;

	// Opcode field in bits 15..12
	typedef enum logic [3:0] {
		op_add  = 4'h0,
		op_sub  = 4'h1,
		op_xor  = 4'h2,
		op_rsv3 = 4'h3,
		op_sll  = 4'h4,
		op_sra  = 4'h5,
		op_ror  = 4'h6,
		op_rsv7 = 4'h7,
		op_lw   = 4'h8,
		op_sw   = 4'h9,
		op_lhb  = 4'ha,
		op_llb  = 4'hb,
		op_b    = 4'hc,
		op_br   = 4'hd,
		op_pcs  = 4'he,
		op_hlt  = 4'hf
	} opcode_e;

	// Branch condition in bits 11..9
	typedef enum logic [2:0] {
		cond_ne = 3'b000,
		cond_eq = 3'b001,
		cond_gt = 3'b010,
		cond_lt = 3'b011,
		cond_ge = 3'b100,
		cond_le = 3'b101,
		cond_ov = 3'b110,
		cond_al = 3'b111
	} cond_e;

	// Bit 2 is z, bit 1 is v, bit 0 is n
	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	typedef enum logic [1:0] {
		fwd_none     = 2'd0,
		fwd_from_mem = 2'd1,
		fwd_from_wb  = 2'd2
	} fwd_sel_e;

endpackage

//--- hdl/mem_if.sv
`timescale 1ns/1ps

interface mem_if
	import cpu_pkg::*;
#(
	parameter int dmem_addr_w = 8
);

	logic                   en;
	logic                   wr;
	logic [data_width-1:0]  addr;
	logic [dmem_addr_w-1:0] word_addr;
	logic [data_width-1:0]  wdata;
	logic [data_width-1:0]  rdata;

	// Word index seen by the memory
	assign word_addr = addr[dmem_addr_w:1];

	modport core (output en, wr, addr, wdata, input rdata);
	modport mem (input en, wr, word_addr, wdata, output rdata);

endinterface

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [3:0]            rd_sel_a,
	input  logic [3:0]            rd_sel_b,
	output logic [data_width-1:0] rd_data_a,
	output logic [data_width-1:0] rd_data_b,
	input  logic                  wr_en,
	input  logic [3:0]            wr_sel,
	input  logic [data_width-1:0] wr_data
);

	logic [data_width-1:0] regs [16];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_sel != 4'd0) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// R0 reads zero
	// Same-cycle write goes straight to the read port
	assign rd_data_a = (rd_sel_a == 4'd0) ? '0 :
		(wr_en && wr_sel == rd_sel_a) ? wr_data : regs[rd_sel_a];
	assign rd_data_b = (rd_sel_b == 4'd0) ? '0 :
		(wr_en && wr_sel == rd_sel_b) ? wr_data : regs[rd_sel_b];

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu
	import cpu_pkg::*;
(
	input  opcode_e               op,
	input  logic [data_width-1:0] in_a,
	input  logic [data_width-1:0] in_b,
	input  logic [3:0]            imm4,
	output logic [data_width-1:0] result,
	output flags_t                flags_new,
	output logic [2:0]            flags_we
);

	logic [data_width-1:0] sum;
	logic [data_width-1:0] diff;
	logic [data_width-1:0] rot;
	logic                  add_ovf;
	logic                  sub_ovf;

	assign sum  = in_a + in_b;
	assign diff = in_a - in_b;
	assign rot  = data_width'({in_a, in_a} >> imm4);

	// Signed overflow from the operand and result signs
	assign add_ovf = (in_a[data_width-1] == in_b[data_width-1]) &&
		(sum[data_width-1] != in_a[data_width-1]);
	assign sub_ovf = (in_a[data_width-1] != in_b[data_width-1]) &&
		(diff[data_width-1] != in_a[data_width-1]);

	always_comb begin
		result      = '0;
		flags_we    = 3'b000;
		flags_new.v = 1'b0;
		case (op)
			op_add: begin
				result      = sum;
				flags_new.v = add_ovf;
				flags_we    = 3'b111;
			end
			op_sub: begin
				result      = diff;
				flags_new.v = sub_ovf;
				flags_we    = 3'b111;
			end
			op_xor: begin
				result   = in_a ^ in_b;
				flags_we = 3'b100;
			end
			op_sll: begin
				result   = in_a << imm4;
				flags_we = 3'b100;
			end
			op_sra: begin
				result   = $signed(in_a) >>> imm4;
				flags_we = 3'b100;
			end
			op_ror: begin
				result   = rot;
				flags_we = 3'b100;
			end
			// Reserved and non-ALU opcodes leave the flags alone
			default: ;
		endcase
		flags_new.z = (result == '0);
		flags_new.n = result[data_width-1];
	end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  squash,
	input  flags_t                flags_new,
	input  logic [2:0]            flags_we,
	input  logic                  is_b,
	input  logic                  is_br,
	input  cond_e                 cond,
	input  logic [8:0]            imm9,
	input  logic [data_width-1:0] pc_plus2,
	input  logic [data_width-1:0] reg_target,
	output logic                  taken,
	output logic [data_width-1:0] target
);

	flags_t flags_q;
	logic   cond_met;

	// Per-flag update, bubbles in execute write nothing
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags_q <= '0;
		end else if (!squash) begin
			flags_q <= flags_t'((flags_we & flags_new) | (~flags_we & flags_q));
		end
	end

	always_comb begin
		case (cond)
			cond_ne: cond_met = !flags_q.z;
			cond_eq: cond_met = flags_q.z;
			cond_gt: cond_met = !flags_q.z && !flags_q.n;
			cond_lt: cond_met = flags_q.n;
			cond_ge: cond_met = flags_q.z || !flags_q.n;
			cond_le: cond_met = flags_q.z || flags_q.n;
			cond_ov: cond_met = flags_q.v;
			default: cond_met = 1'b1;
		endcase
	end

	assign taken  = (is_b || is_br) && cond_met;
	assign target = is_br ? reg_target :
		pc_plus2 + {{(data_width-10){imm9[8]}}, imm9, 1'b0};

endmodule

//--- hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
	import cpu_pkg::*;
(
	input  logic [data_width-1:0] id_instr,
	input  logic [data_width-1:0] ex_instr,
	input  logic                  ex_valid,
	input  logic                  ex_is_load,
	input  logic                  mem_wr_en,
	input  logic [3:0]            mem_sel,
	input  logic                  wb_wr_en,
	input  logic [3:0]            wb_sel,
	input  logic [3:0]            ex_rs,
	input  logic [3:0]            ex_rt,
	output logic                  stall,
	output fwd_sel_e              fwd_a,
	output fwd_sel_e              fwd_b,
	output logic                  halt_decoded
);

	opcode_e    id_op;
	logic [3:0] load_rd;
	logic       uses_rs;
	logic       uses_rt;
	logic       uses_rd;

	assign id_op   = opcode_e'(id_instr[15:12]);
	assign load_rd = ex_instr[11:8];

	// Which fields the decode instruction reads
	always_comb begin
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		uses_rd = 1'b0;
		case (id_op)
			op_add, op_sub, op_xor: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			op_sll, op_sra, op_ror, op_lw, op_br: begin
				uses_rs = 1'b1;
			end
			op_sw: begin
				uses_rs = 1'b1;
				uses_rd = 1'b1;
			end
			op_lhb, op_llb: begin
				uses_rd = 1'b1;
			end
			default: ;
		endcase
	end

	assign stall = ex_valid && ex_is_load && load_rd != 4'd0 &&
		((uses_rs && id_instr[7:4] == load_rd) ||
		(uses_rt && id_instr[3:0] == load_rd) ||
		(uses_rd && id_instr[11:8] == load_rd));

	// Memory stage holds the younger result and wins
	assign fwd_a = (mem_wr_en && mem_sel != 4'd0 && mem_sel == ex_rs) ? fwd_from_mem :
		(wb_wr_en && wb_sel != 4'd0 && wb_sel == ex_rs) ? fwd_from_wb : fwd_none;
	assign fwd_b = (mem_wr_en && mem_sel != 4'd0 && mem_sel == ex_rt) ? fwd_from_mem :
		(wb_wr_en && wb_sel != 4'd0 && wb_sel == ex_rt) ? fwd_from_wb : fwd_none;

	assign halt_decoded = (id_op == op_hlt);

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	output logic [data_width-1:0] fetch_addr,
	input  logic [data_width-1:0] fetch_instr,
	mem_if.core                   dmem,
	output logic                  hlt,
	output logic [data_width-1:0] pc_out,
	output logic                  wb_valid,
	output logic [3:0]            wb_sel,
	output logic [data_width-1:0] wb_data
);

	typedef struct packed {
		logic wr_en;
		logic is_load;
		logic is_store;
		logic is_hlt;
	} ctrl_t;

	// Fetch and global control
	logic [data_width-1:0] pc_q;
	logic [data_width-1:0] pc_plus2;
	logic                  hz_stall;
	logic                  stall;
	logic                  halt_decoded;
	logic                  halting;
	logic                  freeze_q;
	logic                  hlt_q;
	logic                  taken;
	logic [data_width-1:0] target;
	// Decode
	logic                  id_valid;
	logic [data_width-1:0] id_instr;
	logic [data_width-1:0] id_pc2;
	opcode_e               id_op;
	logic [3:0]            id_sel_a;
	logic [3:0]            id_sel_b;
	logic [data_width-1:0] id_data_a;
	logic [data_width-1:0] id_data_b;
	ctrl_t                 id_ctrl;
	// Execute
	logic                  ex_valid;
	logic [data_width-1:0] ex_instr;
	logic [data_width-1:0] ex_pc2;
	logic [data_width-1:0] ex_a;
	logic [data_width-1:0] ex_b;
	logic [3:0]            ex_rs;
	logic [3:0]            ex_rt;
	ctrl_t                 ex_ctrl;
	opcode_e               ex_op;
	fwd_sel_e              fwd_a;
	fwd_sel_e              fwd_b;
	logic [data_width-1:0] in_a;
	logic [data_width-1:0] in_b;
	logic [data_width-1:0] alu_result;
	flags_t                flags_new;
	logic [2:0]            flags_we;
	logic [data_width-1:0] ex_result;
	logic [data_width-1:0] ex_addr;
	// Memory
	logic                  mem_valid;
	ctrl_t                 mem_ctrl;
	logic [3:0]            mem_rd;
	logic [data_width-1:0] mem_result;
	logic [data_width-1:0] mem_addr;
	logic [data_width-1:0] mem_sdata;
	logic [data_width-1:0] mem_data;
	// Writeback
	logic                  wbs_valid;
	logic                  wbs_wr_en;
	logic [3:0]            wbs_rd;
	logic [data_width-1:0] wbs_data;
	logic                  rf_we;

	// ----------------------------------------
	// Control state
	// ----------------------------------------
	assign stall   = hz_stall && id_valid;
	assign halting = id_valid && halt_decoded && !taken;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q      <= '0;
			id_valid  <= 1'b0;
			ex_valid  <= 1'b0;
			mem_valid <= 1'b0;
			wbs_valid <= 1'b0;
			freeze_q  <= 1'b0;
			hlt_q     <= 1'b0;
		end else begin
			if (taken) begin
				pc_q <= target;
			end else if (!stall && !halting && !freeze_q) begin
				pc_q <= pc_plus2;
			end
			// Taken branch and HLT both stop younger fetches
			if (taken || halting || freeze_q) begin
				id_valid <= 1'b0;
			end else if (!stall) begin
				id_valid <= 1'b1;
			end
			ex_valid  <= id_valid && !stall && !taken;
			mem_valid <= ex_valid;
			wbs_valid <= mem_valid;
			freeze_q  <= freeze_q || halting;
			hlt_q     <= hlt_q || (mem_valid && mem_ctrl.is_hlt);
		end
	end

	// Stage payloads, meaningful only under their valid bit
	always_ff @(posedge clk) begin
		if (!stall) begin
			id_instr <= fetch_instr;
			id_pc2   <= pc_plus2;
		end
		ex_instr   <= id_instr;
		ex_pc2     <= id_pc2;
		ex_a       <= id_data_a;
		ex_b       <= id_data_b;
		ex_rs      <= id_sel_a;
		ex_rt      <= id_sel_b;
		ex_ctrl    <= id_ctrl;
		mem_ctrl   <= ex_ctrl;
		mem_rd     <= ex_instr[11:8];
		mem_result <= ex_result;
		mem_addr   <= ex_addr;
		mem_sdata  <= in_b;
		wbs_wr_en  <= mem_ctrl.wr_en;
		wbs_rd     <= mem_rd;
		wbs_data   <= mem_data;
	end

	// ----------------------------------------
	// Fetch and decode
	// ----------------------------------------
	assign pc_plus2   = pc_q + data_width'(2);
	assign fetch_addr = pc_q;
	assign pc_out     = pc_q;

	assign id_op = opcode_e'(id_instr[15:12]);
	// LHB and LLB merge into rd, SW stores rd
	assign id_sel_a = (id_op == op_lhb || id_op == op_llb) ? id_instr[11:8] : id_instr[7:4];
	assign id_sel_b = (id_op == op_sw) ? id_instr[11:8] : id_instr[3:0];

	always_comb begin
		id_ctrl.is_load  = (id_op == op_lw);
		id_ctrl.is_store = (id_op == op_sw);
		id_ctrl.is_hlt   = halt_decoded;
		case (id_op)
			op_add, op_sub, op_xor, op_sll, op_sra, op_ror,
			op_lw, op_lhb, op_llb, op_pcs: id_ctrl.wr_en = 1'b1;
			default: id_ctrl.wr_en = 1'b0;
		endcase
	end

	reg_file reg_file_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_sel_a  (id_sel_a),
		.rd_sel_b  (id_sel_b),
		.rd_data_a (id_data_a),
		.rd_data_b (id_data_b),
		.wr_en     (rf_we),
		.wr_sel    (wbs_rd),
		.wr_data   (wbs_data)
	);

	hazard_unit hazard_unit_i (
		.id_instr     (id_instr),
		.ex_instr     (ex_instr),
		.ex_valid     (ex_valid),
		.ex_is_load   (ex_ctrl.is_load),
		.mem_wr_en    (mem_valid && mem_ctrl.wr_en),
		.mem_sel      (mem_rd),
		.wb_wr_en     (rf_we),
		.wb_sel       (wbs_rd),
		.ex_rs        (ex_rs),
		.ex_rt        (ex_rt),
		.stall        (hz_stall),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.halt_decoded (halt_decoded)
	);

	// ----------------------------------------
	// Execute
	// ----------------------------------------
	assign ex_op = opcode_e'(ex_instr[15:12]);
	assign in_a  = (fwd_a == fwd_from_mem) ? mem_data :
		(fwd_a == fwd_from_wb) ? wbs_data : ex_a;
	assign in_b  = (fwd_b == fwd_from_mem) ? mem_data :
		(fwd_b == fwd_from_wb) ? wbs_data : ex_b;

	always_comb begin
		case (ex_op)
			op_lhb:  ex_result = {ex_instr[7:0], in_a[7:0]};
			op_llb:  ex_result = {in_a[15:8], ex_instr[7:0]};
			op_pcs:  ex_result = ex_pc2;
			default: ex_result = alu_result;
		endcase
	end

	// Base plus sign-extended word offset
	assign ex_addr = in_a + {{(data_width-5){ex_instr[3]}}, ex_instr[3:0], 1'b0};

	alu alu_i (
		.op        (ex_op),
		.in_a      (in_a),
		.in_b      (in_b),
		.imm4      (ex_instr[3:0]),
		.result    (alu_result),
		.flags_new (flags_new),
		.flags_we  (flags_we)
	);

	branch_unit branch_unit_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.squash     (!ex_valid),
		.flags_new  (flags_new),
		.flags_we   (flags_we),
		.is_b       (ex_valid && ex_op == op_b),
		.is_br      (ex_valid && ex_op == op_br),
		.cond       (cond_e'(ex_instr[11:9])),
		.imm9       (ex_instr[8:0]),
		.pc_plus2   (ex_pc2),
		.reg_target (in_a),
		.taken      (taken),
		.target     (target)
	);

	// ----------------------------------------
	// Memory and writeback
	// ----------------------------------------
	assign dmem.en    = mem_valid && (mem_ctrl.is_load || mem_ctrl.is_store);
	assign dmem.wr    = mem_valid && mem_ctrl.is_store;
	assign dmem.addr  = mem_addr;
	assign dmem.wdata = mem_sdata;
	assign mem_data   = mem_ctrl.is_load ? dmem.rdata : mem_result;

	assign rf_we    = wbs_valid && wbs_wr_en;
	assign wb_valid = rf_we && wbs_rd != 4'd0;
	assign wb_sel   = wbs_rd;
	assign wb_data  = wbs_data;
	assign hlt      = hlt_q;

endmodule

//--- hdl/instr_mem.sv
`timescale 1ns/1ps

module instr_mem
	import cpu_pkg::*;
#(
	parameter int imem_addr_w = 8
) (
	input  logic                  clk,
	input  logic                  load_we,
	input  logic [data_width-1:0] load_addr,
	input  logic [data_width-1:0] load_data,
	input  logic [data_width-1:0] fetch_addr,
	output logic [data_width-1:0] fetch_instr
);

	logic [data_width-1:0] mem [2**imem_addr_w];

	// Program load, byte address dropped to a word index
	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load_addr[imem_addr_w:1]] <= load_data;
		end
	end

	assign fetch_instr = mem[fetch_addr[imem_addr_w:1]];

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/1ps

module data_mem
	import cpu_pkg::*;
#(
	parameter int dmem_addr_w = 8
) (
	input logic clk,
	mem_if.mem  port
);

	// Unwritten words read zero
	logic [data_width-1:0] mem [2**dmem_addr_w] = '{default: '0};

	always_ff @(posedge clk) begin
		if (port.en && port.wr) begin
			mem[port.word_addr] <= port.wdata;
		end
	end

	// Read data only during a read access
	assign port.rdata = (port.en && !port.wr) ? mem[port.word_addr] : '0;

endmodule

//--- hdl/cpu_system.sv
`timescale 1ns/1ps

module cpu_system
	import cpu_pkg::*;
#(
	parameter int imem_addr_w = 8,
	parameter int dmem_addr_w = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  imem_we,
	input  logic [data_width-1:0] imem_addr,
	input  logic [data_width-1:0] imem_wdata,
	output logic                  hlt,
	output logic [data_width-1:0] pc_out,
	output logic                  wb_valid,
	output logic [3:0]            wb_sel,
	output logic [data_width-1:0] wb_data
);

	logic [data_width-1:0] fetch_addr;
	logic [data_width-1:0] fetch_instr;

	mem_if #(.dmem_addr_w(dmem_addr_w)) dmem_bus ();

	cpu_core core_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_addr  (fetch_addr),
		.fetch_instr (fetch_instr),
		.dmem        (dmem_bus.core),
		.hlt         (hlt),
		.pc_out      (pc_out),
		.wb_valid    (wb_valid),
		.wb_sel      (wb_sel),
		.wb_data     (wb_data)
	);

	instr_mem #(.imem_addr_w(imem_addr_w)) imem_i (
		.clk         (clk),
		.load_we     (imem_we),
		.load_addr   (imem_addr),
		.load_data   (imem_wdata),
		.fetch_addr  (fetch_addr),
		.fetch_instr (fetch_instr)
	);

	data_mem #(.dmem_addr_w(dmem_addr_w)) dmem_i (
		.clk  (clk),
		.port (dmem_bus.mem)
	);

endmodule

//--- verif/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker
	import cpu_pkg::*;
(
	input logic                  clk,
	input logic                  rst_n,
	input logic                  hlt,
	input logic [data_width-1:0] pc_out,
	input logic                  wb_valid,
	input logic [3:0]            wb_sel
);

	// Reset clears the halt and the retire port
	reset_clears: assert property (@(posedge clk)
		!rst_n |=> !hlt && !wb_valid)
		else $error("hlt or wb_valid high right after a reset cycle");

	// R0 writes are never retired
	no_r0_retire: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> wb_sel != 4'd0)
		else $error("wb_valid raised for r0");

	pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		pc_out[0] == 1'b0)
		else $error("pc_out is not word aligned");

	// ----------------------------------------
	// Halted state
	// ----------------------------------------
	halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		hlt |=> hlt)
		else $error("hlt dropped without a reset");

	halt_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
		hlt |=> $stable(pc_out))
		else $error("pc_out moved after halt");

	halt_no_retire: assert property (@(posedge clk) disable iff (!rst_n)
		hlt |=> !wb_valid)
		else $error("Retirement after halt");

endmodule

//--- verif/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu
	import cpu_pkg::*;
();

	localparam int clk_period      = 20;
	localparam int prog_words      = 32;
	localparam int num_retires     = 18;
	localparam int load_use_idx    = 11;
	localparam int watchdog_cycles = 28 * 3 + 40;

	logic                  clk;
	logic                  rst_n;
	logic                  imem_we;
	logic [data_width-1:0] imem_addr;
	logic [data_width-1:0] imem_wdata;
	logic                  hlt;
	logic [data_width-1:0] pc_out;
	logic                  wb_valid;
	logic [3:0]            wb_sel;
	logic [data_width-1:0] wb_data;

	logic [15:0] program_words [prog_words];
	logic [data_width-1:0] halt_pc;
	int retire_idx = 0;
	time last_retire_time = 0;

	// Register and value of each retirement in program order
	logic [3:0] exp_sel [num_retires] = '{
		4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9,
		4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd14, 4'd15, 4'd15, 4'd2
	};
	logic [15:0] exp_data [num_retires] = '{
		16'h0005, 16'h0003, 16'h0008, 16'h0003, 16'h000b, 16'h00b0,
		16'h002c, 16'hc002, 16'h8000, 16'hf000, 16'hf000, 16'hf005,
		16'h0005, 16'h0000, 16'hfffe, 16'h0032, 16'h003a, 16'hffc4
	};

	cpu_system cpu_system_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.hlt        (hlt),
		.pc_out     (pc_out),
		.wb_valid   (wb_valid),
		.wb_sel     (wb_sel),
		.wb_data    (wb_data)
	);

	bind cpu_system cpu_checker cpu_checker_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.hlt      (hlt),
		.pc_out   (pc_out),
		.wb_valid (wb_valid),
		.wb_sel   (wb_sel)
	);

	// ----------------------------------------
	// Instruction encoding
	// ----------------------------------------
	function automatic logic [15:0] alu_word(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] byte_word(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] imm8);
		return {op, rd, imm8};
	endfunction

	function automatic logic [15:0] branch_word(input logic [2:0] cond, input logic [8:0] imm9);
		return {4'hc, cond, imm9};
	endfunction

	function automatic logic [15:0] reg_branch_word(input logic [2:0] cond,
		input logic [3:0] rs);
		return {4'hd, cond, 1'b0, rs, 4'h0};
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic build_program();
		// Arithmetic chain with forwarding from both stages
		program_words[0]  = byte_word(op_llb, 4'd1, 8'h05);
		program_words[1]  = byte_word(op_llb, 4'd2, 8'h03);
		program_words[2]  = alu_word(op_add, 4'd3, 4'd1, 4'd2);
		program_words[3]  = alu_word(op_sub, 4'd4, 4'd3, 4'd1);
		program_words[4]  = alu_word(op_xor, 4'd5, 4'd4, 4'd3);
		program_words[5]  = alu_word(op_sll, 4'd6, 4'd5, 4'd4);
		program_words[6]  = alu_word(op_sra, 4'd7, 4'd6, 4'd2);
		program_words[7]  = alu_word(op_ror, 4'd8, 4'd7, 4'd4);
		program_words[8]  = byte_word(op_lhb, 4'd9, 8'h80);
		program_words[9]  = alu_word(op_sra, 4'd10, 4'd9, 4'd3);
		// Store, load back, then a load-use pair
		program_words[10] = alu_word(op_sw, 4'd10, 4'd0, 4'd2);
		program_words[11] = alu_word(op_lw, 4'd11, 4'd0, 4'd2);
		program_words[12] = alu_word(op_add, 4'd12, 4'd11, 4'd1);
		// R0 write dropped and then read as zero
		program_words[13] = alu_word(op_add, 4'd0, 4'd1, 4'd2);
		program_words[14] = alu_word(op_add, 4'd13, 4'd0, 4'd1);
		program_words[15] = alu_word(op_sub, 4'd14, 4'd1, 4'd1);
		program_words[16] = branch_word(cond_ne, 9'd2);
		program_words[17] = branch_word(cond_eq, 9'd2);
		program_words[18] = byte_word(op_llb, 4'd15, 8'hee);
		program_words[19] = byte_word(op_llb, 4'd15, 8'hdd);
		program_words[20] = alu_word(op_sub, 4'd14, 4'd2, 4'd1);
		program_words[21] = branch_word(cond_gt, 9'd1);
		program_words[22] = branch_word(cond_lt, 9'd1);
		program_words[23] = byte_word(op_llb, 4'd15, 8'hcc);
		// PCS, offset, then jump through the register
		program_words[24] = alu_word(op_pcs, 4'd15, 4'd0, 4'd0);
		program_words[25] = alu_word(op_add, 4'd15, 4'd15, 4'd3);
		program_words[26] = reg_branch_word(cond_al, 4'd15);
		program_words[27] = byte_word(op_llb, 4'd15, 8'haa);
		program_words[28] = byte_word(op_llb, 4'd15, 8'hbb);
		program_words[29] = alu_word(op_xor, 4'd2, 4'd15, 4'd14);
		program_words[30] = alu_word(op_hlt, 4'd0, 4'd0, 4'd0);
		// Fetched behind HLT but never entered
		program_words[31] = byte_word(op_llb, 4'd1, 8'h77);
	endtask

	// ----------------------------------------
	// Clock, load and run
	// ----------------------------------------
	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		rst_n      = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		build_program();
		// Program goes in while the core sits in reset
		for (int i = 0; i < prog_words; i++) begin
			@(negedge clk);
			imem_we    = 1'b1;
			imem_addr  = 16'(i * 2);
			imem_wdata = program_words[i];
		end
		@(negedge clk);
		imem_we = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		while (!hlt) @(negedge clk);
		halt_pc = pc_out;
		repeat (5) @(negedge clk);
		if (pc_out != halt_pc) begin
			abort_run($sformatf("PC moved from %h to %h after halt", halt_pc, pc_out));
		end else if (retire_idx != num_retires) begin
			abort_run($sformatf("Halted after %0d of %0d expected retirements",
				retire_idx, num_retires));
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

	// Compare every retirement with the table
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (retire_idx >= num_retires) begin
				abort_run($sformatf("Unexpected retirement of r%0d past the list",
					wb_sel));
			end else begin
				assert (wb_sel == exp_sel[retire_idx] && wb_data == exp_data[retire_idx])
				else
					abort_run($sformatf(
						"MISMATCH at %0t: retire %0d wrote r%0d = %h, expected r%0d = %h",
						$time, retire_idx, wb_sel, wb_data,
						exp_sel[retire_idx], exp_data[retire_idx]));
				// Load-use stall leaves one bubble between the two retirements
				assert (retire_idx != load_use_idx ||
					$time - last_retire_time == 2 * clk_period)
				else
					abort_run($sformatf(
						"MISMATCH at %0t: load user retired %0d ns after the load, expected %0d",
						$time, $time - last_retire_time, 2 * clk_period));
				last_retire_time = $time;
				retire_idx = retire_idx + 1;
			end
		end
	end

	initial begin
		wait (rst_n === 1'b1);
		repeat (watchdog_cycles) @(posedge clk);
		abort_run("Watchdog expired before the processor halted");
	end

endmodule

//--- verilog.f
hdl/cpu_pkg.sv
hdl/mem_if.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/hazard_unit.sv
hdl/cpu_core.sv
hdl/instr_mem.sv
hdl/data_mem.sv
hdl/cpu_system.sv
verif/cpu_checker.sv
verif/tb_cpu.sv

//--- Makefile
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

# Pass only when the run prints the pass line
sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
